/* source/rtos_cfg.svh */
// Size settings of the RTOS kernel core.
// Included by the package and by every module that sizes arrays or loops.
// Change the values here to rebuild the kernel with other dimensions.

`ifndef RTOS_CFG_SVH
`define RTOS_CFG_SVH

// --------------------------------------------------
// object counts
// --------------------------------------------------
`define RTOS_TASKS          8
`define RTOS_SEMAPHORES     2

// --------------------------------------------------
// field widths
// --------------------------------------------------
// lower priority value wins
`define RTOS_TSKPRI_WIDTH   3
`define RTOS_SEMCNT_WIDTH   4
`define RTOS_FLGPTN_WIDTH   8

`endif

/* source/rtos_pkg.sv */
// Shared types of the RTOS kernel core.
// Modules import it in their bodies and use scoped names in their headers.
// The fixed task priorities live here as a constant table.

`default_nettype none

`include "rtos_cfg.svh"

package rtos_pkg;

    typedef logic [$clog2(`RTOS_TASKS)-1:0]      tskid_t;
    typedef logic [`RTOS_TSKPRI_WIDTH-1:0]       tskpri_t;
    typedef logic [$clog2(`RTOS_SEMAPHORES)-1:0] semid_t;
    typedef logic [`RTOS_SEMCNT_WIDTH-1:0]       semcnt_t;
    typedef logic [`RTOS_FLGPTN_WIDTH-1:0]       flgptn_t;

    // per-task scheduling state
    typedef enum logic [1:0] {ready, sleep, wait_sem, wait_flg} tsk_state_e;

    // event-flag wait mode
    typedef enum logic {wf_and, wf_or} wfmode_e;

    // fixed priority of every task, indexed by id
    localparam tskpri_t tskpri_tbl [`RTOS_TASKS] = '{3, 1, 2, 1, 0, 2, 3, 1};

endpackage

`default_nettype wire

/* source/rtos_queue_if.sv */
// Connection between a priority queue and the block that uses it.
// The user drives single-cycle add and remove strobes; the queue answers
// with its registered top entry. There is no handshake on either side.

`default_nettype none

interface rtos_queue_if;

    import rtos_pkg::*;

    // add a task id to the set
    tskid_t  add_id;
    logic    add_valid;

    // remove a task id from the set
    tskid_t  rmv_id;
    logic    rmv_valid;

    // best member, one cycle behind the set
    tskid_t  top_id;
    tskpri_t top_pri;
    logic    top_valid;

    modport user (
        output add_id, add_valid, rmv_id, rmv_valid,
        input  top_id, top_pri, top_valid
    );

    modport queue (
        input  add_id, add_valid, rmv_id, rmv_valid,
        output top_id, top_pri, top_valid
    );

endinterface

`default_nettype wire

/* source/rtos_prio_queue.sv */
// Priority-ordered set of task ids.
// Membership is one bit per task; the best member (lowest priority value,
// lowest id on a tie) is picked combinationally and registered as the top.
// INIT_FULL selects whether the set holds every task after reset.

`default_nettype none

`include "rtos_cfg.svh"

module rtos_prio_queue #(
    parameter bit INIT_FULL = 1'b0
) (
    input wire          clk,
    input wire          rst_n,
    rtos_queue_if.queue q
);

    import rtos_pkg::*;

    logic [`RTOS_TASKS-1:0] member;

    tskid_t  best_id;
    tskpri_t best_pri;
    logic    best_found;

    // --------------------------------------------------
    // membership
    // --------------------------------------------------
    // add and remove of different ids may land together
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            member <= {`RTOS_TASKS{INIT_FULL}};
        end else begin
            if (q.add_valid) begin
                member[q.add_id] <= 1'b1;
            end
            if (q.rmv_valid) begin
                member[q.rmv_id] <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // top selection
    // --------------------------------------------------
    // ascending scan with strict compare keeps the lower id on ties
    always_comb begin
        best_id    = '0;
        best_pri   = '1;
        best_found = 1'b0;
        for (int i = 0; i < `RTOS_TASKS; i++) begin
            if (member[i] && (!best_found || tskpri_tbl[i] < best_pri)) begin
                best_id    = tskid_t'(i);
                best_pri   = tskpri_tbl[i];
                best_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q.top_id    <= '0;
            q.top_pri   <= '0;
            q.top_valid <= 1'b0;
        end else begin
            q.top_id    <= best_id;
            q.top_pri   <= best_pri;
            q.top_valid <= best_found;
        end
    end

endmodule

`default_nettype wire

/* source/rtos_task.sv */
// State machine of a single task.
// Takes per-task call strobes decoded by the core and raises req_rdy when
// a sleep or wait ends. The request is held until the core grants this
// task id, at which point the task is ready again.

`default_nettype none

module rtos_task #(
    parameter rtos_pkg::tskid_t TSKID = '0
) (
    input wire                    clk,
    input wire                    rst_n,
    input wire rtos_pkg::tskid_t  rdy_grant,
    input wire                    wup_tsk,
    input wire                    slp_tsk,
    input wire                    wai_sem,
    input wire                    wai_flg,
    input wire                    sem_wakeup,
    input wire                    rel_wai,
    input wire rtos_pkg::wfmode_e wai_flg_wfmode,
    input wire rtos_pkg::flgptn_t wai_flg_flgptn,
    input wire rtos_pkg::flgptn_t evtflg_flgptn,
    output logic                  req_rdy
);

    import rtos_pkg::*;

    tsk_state_e state;
    flgptn_t    wait_ptn;
    wfmode_e    wait_mode;
    logic       flg_match;
    logic       granted;

    // grant id only matters while a request is pending
    assign granted = req_rdy && (rdy_grant == TSKID);

    always_comb begin
        if (wait_mode == wf_and) begin
            flg_match = ((evtflg_flgptn & wait_ptn) == wait_ptn);
        end else begin
            flg_match = |(evtflg_flgptn & wait_ptn);
        end
    end

    // --------------------------------------------------
    // state transitions
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ready;
            req_rdy <= 1'b0;
        end else if (req_rdy) begin
            if (granted) begin
                req_rdy <= 1'b0;
                state   <= ready;
            end
        end else begin
            case (state)
                ready: begin
                    if (slp_tsk) begin
                        state <= sleep;
                    end else if (wai_sem) begin
                        state <= wait_sem;
                    end else if (wai_flg) begin
                        state <= wait_flg;
                    end
                end
                sleep:    req_rdy <= wup_tsk;
                wait_sem: req_rdy <= sem_wakeup || rel_wai;
                wait_flg: req_rdy <= rel_wai || flg_match;
                default:  state <= ready;
            endcase
        end
    end

    // wait condition, captured when the task blocks on the flag
    always_ff @(posedge clk) begin
        if (wai_flg && state == ready && !req_rdy) begin
            wait_ptn  <= wai_flg_flgptn;
            wait_mode <= wai_flg_wfmode;
        end
    end

endmodule

`default_nettype wire

/* source/rtos_semaphore.sv */
// Counting semaphore with a priority-ordered wait set.
// The core only sends a waiter here when the count is zero, and drives
// wai_sem_take when a wait consumes a nonzero count instead. A signal
// hands the resource to the best waiter if there is one, otherwise it
// bumps the count.

`default_nettype none

module rtos_semaphore (
    input wire                   clk,
    input wire                   rst_n,
    input wire                   sig_sem,
    input wire rtos_pkg::tskid_t wai_sem_tskid,
    input wire                   wai_sem_valid,
    input wire                   wai_sem_take,
    input wire rtos_pkg::tskid_t rel_wai_tskid,
    input wire                   rel_wai_valid,
    output wire rtos_pkg::tskid_t wakeup_tskid,
    output wire                  wakeup_valid,
    output rtos_pkg::semcnt_t    semcnt
);

    rtos_queue_if wait_if ();

    // --------------------------------------------------
    // wait set
    // --------------------------------------------------
    rtos_prio_queue #(
        .INIT_FULL (1'b0)
    ) i_wait_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .q     (wait_if.queue)
    );

    // only one call strobe per cycle, so the removes never collide
    always_comb begin
        wait_if.add_id    = wai_sem_tskid;
        wait_if.add_valid = wai_sem_valid;
        wait_if.rmv_id    = rel_wai_tskid;
        wait_if.rmv_valid = rel_wai_valid;
        if (sig_sem && wait_if.top_valid) begin
            wait_if.rmv_id    = wait_if.top_id;
            wait_if.rmv_valid = 1'b1;
        end
    end

    assign wakeup_tskid = wait_if.top_id;
    assign wakeup_valid = sig_sem && wait_if.top_valid;

    // --------------------------------------------------
    // count
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            semcnt <= '0;
        end else if (sig_sem && !wait_if.top_valid) begin
            // saturate at full scale
            if (semcnt != '1) begin
                semcnt <= semcnt + 1'b1;
            end
        end else if (wai_sem_take) begin
            semcnt <= semcnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/rtos_core.sv */
// Top level of the RTOS kernel core.
// Decodes single-cycle service calls into per-task and per-semaphore
// strobes, holds the event-flag register and feeds the ready queue.
// Wait calls act on the running task, which is the ready-queue top.
// At most one call strobe may be high in a cycle.

`default_nettype none

`include "rtos_cfg.svh"

module rtos_core (
    input wire                    clk,
    input wire                    rst_n,
    input wire rtos_pkg::tskid_t  wup_tsk_tskid,
    input wire                    wup_tsk_valid,
    input wire rtos_pkg::tskid_t  slp_tsk_tskid,
    input wire                    slp_tsk_valid,
    input wire rtos_pkg::tskid_t  rel_wai_tskid,
    input wire                    rel_wai_valid,
    input wire rtos_pkg::semid_t  wai_sem_semid,
    input wire                    wai_sem_valid,
    input wire rtos_pkg::semid_t  sig_sem_semid,
    input wire                    sig_sem_valid,
    input wire rtos_pkg::wfmode_e wai_flg_wfmode,
    input wire rtos_pkg::flgptn_t wai_flg_flgptn,
    input wire                    wai_flg_valid,
    input wire rtos_pkg::flgptn_t set_flg,
    input wire rtos_pkg::flgptn_t clr_flg,
    output wire rtos_pkg::tskid_t rdq_top_tskid,
    output wire rtos_pkg::tskpri_t rdq_top_tskpri,
    output wire                   rdq_top_valid,
    output rtos_pkg::flgptn_t     evtflg_flgptn,
    output wire rtos_pkg::semcnt_t [`RTOS_SEMAPHORES-1:0] semcnt
);

    import rtos_pkg::*;

    rtos_queue_if rdq_if ();

    logic [`RTOS_TASKS-1:0] task_req_rdy;
    logic [`RTOS_TASKS-1:0] task_wup_tsk;
    logic [`RTOS_TASKS-1:0] task_slp_tsk;
    logic [`RTOS_TASKS-1:0] task_wai_sem;
    logic [`RTOS_TASKS-1:0] task_wai_flg;
    logic [`RTOS_TASKS-1:0] task_sem_wakeup;
    logic [`RTOS_TASKS-1:0] task_rel_wai;
    tskid_t                 rdy_grant;

    logic   [`RTOS_SEMAPHORES-1:0] sem_sig;
    logic   [`RTOS_SEMAPHORES-1:0] sem_wai;
    logic   [`RTOS_SEMAPHORES-1:0] sem_take;
    tskid_t [`RTOS_SEMAPHORES-1:0] sem_wakeup_tskid;
    logic   [`RTOS_SEMAPHORES-1:0] sem_wakeup_valid;

    // --------------------------------------------------
    // ready queue
    // --------------------------------------------------
    rtos_prio_queue #(
        .INIT_FULL (1'b1)
    ) i_ready_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .q     (rdq_if.queue)
    );

    assign rdq_top_tskid  = rdq_if.top_id;
    assign rdq_top_tskpri = rdq_if.top_pri;
    assign rdq_top_valid  = rdq_if.top_valid;

    // lowest requesting id wins; the scan runs downward so it ends there
    always_comb begin
        rdy_grant = '0;
        for (int i = `RTOS_TASKS - 1; i >= 0; i--) begin
            if (task_req_rdy[i]) begin
                rdy_grant = tskid_t'(i);
            end
        end
    end

    // --------------------------------------------------
    // tasks and semaphores
    // --------------------------------------------------
    for (genvar i = 0; i < `RTOS_TASKS; i++) begin : g_task
        rtos_task #(
            .TSKID (tskid_t'(i))
        ) i_rtos_task (
            .clk            (clk),
            .rst_n          (rst_n),
            .rdy_grant      (rdy_grant),
            .wup_tsk        (task_wup_tsk[i]),
            .slp_tsk        (task_slp_tsk[i]),
            .wai_sem        (task_wai_sem[i]),
            .wai_flg        (task_wai_flg[i]),
            .sem_wakeup     (task_sem_wakeup[i]),
            .rel_wai        (task_rel_wai[i]),
            .wai_flg_wfmode (wai_flg_wfmode),
            .wai_flg_flgptn (wai_flg_flgptn),
            .evtflg_flgptn  (evtflg_flgptn),
            .req_rdy        (task_req_rdy[i])
        );
    end

    for (genvar s = 0; s < `RTOS_SEMAPHORES; s++) begin : g_sem
        rtos_semaphore i_rtos_semaphore (
            .clk           (clk),
            .rst_n         (rst_n),
            .sig_sem       (sem_sig[s]),
            .wai_sem_tskid (rdq_if.top_id),
            .wai_sem_valid (sem_wai[s]),
            .wai_sem_take  (sem_take[s]),
            .rel_wai_tskid (rel_wai_tskid),
            .rel_wai_valid (rel_wai_valid),
            .wakeup_tskid  (sem_wakeup_tskid[s]),
            .wakeup_valid  (sem_wakeup_valid[s]),
            .semcnt        (semcnt[s])
        );
    end

    // --------------------------------------------------
    // call decoding
    // --------------------------------------------------
    always_comb begin
        task_wup_tsk      = '0;
        task_slp_tsk      = '0;
        task_wai_sem      = '0;
        task_wai_flg      = '0;
        task_sem_wakeup   = '0;
        task_rel_wai      = '0;
        sem_sig           = '0;
        sem_wai           = '0;
        sem_take          = '0;
        rdq_if.rmv_id     = slp_tsk_tskid;
        rdq_if.rmv_valid  = 1'b0;
        rdq_if.add_id     = rdy_grant;
        rdq_if.add_valid  = |task_req_rdy;

        if (wup_tsk_valid) begin
            task_wup_tsk[wup_tsk_tskid] = 1'b1;
        end
        if (slp_tsk_valid) begin
            task_slp_tsk[slp_tsk_tskid] = 1'b1;
            rdq_if.rmv_valid            = 1'b1;
        end
        if (rel_wai_valid) begin
            task_rel_wai[rel_wai_tskid] = 1'b1;
        end
        if (sig_sem_valid) begin
            sem_sig[sig_sem_semid] = 1'b1;
        end

        // a wait that finds a nonzero count just takes it and keeps running
        if (wai_sem_valid && rdq_if.top_valid) begin
            if (semcnt[wai_sem_semid] == '0) begin
                task_wai_sem[rdq_if.top_id] = 1'b1;
                sem_wai[wai_sem_semid]      = 1'b1;
                rdq_if.rmv_id               = rdq_if.top_id;
                rdq_if.rmv_valid            = 1'b1;
            end else begin
                sem_take[wai_sem_semid] = 1'b1;
            end
        end

        if (wai_flg_valid && rdq_if.top_valid) begin
            task_wai_flg[rdq_if.top_id] = 1'b1;
            rdq_if.rmv_id               = rdq_if.top_id;
            rdq_if.rmv_valid            = 1'b1;
        end

        for (int s = 0; s < `RTOS_SEMAPHORES; s++) begin
            if (sem_wakeup_valid[s]) begin
                task_sem_wakeup[sem_wakeup_tskid[s]] = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // event flag
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            evtflg_flgptn <= '0;
        end else begin
            evtflg_flgptn <= (evtflg_flgptn | set_flg) & ~clr_flg;
        end
    end

endmodule

`default_nettype wire

/* sim/rtos_clkgen.sv */
// Clock and reset source for the kernel testbench.
// Free-running clock; rst_n is held low for RESET_CYCLES rising edges
// and released on the following falling edge.

`default_nettype none

module rtos_clkgen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

    // release away from the active edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/rtos_checker.sv */
// Concurrent assertions on the kernel core, attached to rtos_core by bind.
// Watches the call strobes, the ready-queue top and the ready-queue add.

`default_nettype none

`include "rtos_cfg.svh"

module rtos_checker (
    input wire                    clk,
    input wire                    rst_n,
    input wire [5:0]              call_valid,
    input wire rtos_pkg::tskid_t  rdq_top_tskid,
    input wire rtos_pkg::tskpri_t rdq_top_tskpri,
    input wire                    rdq_top_valid,
    input wire rtos_pkg::tskid_t  add_id,
    input wire                    add_valid,
    input wire [`RTOS_TASKS-1:0]  ready_member
);

    import rtos_pkg::*;

    // callers raise at most one service call per cycle
    a_one_call: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(call_valid))
        else $error("more than one service call strobe in one cycle");

    // top register is cleared by the time reset has been seen on an edge
    a_reset_top: assert property (@(posedge clk) !rst_n |=> !rdq_top_valid)
        else $error("ready-queue top valid while in reset");

    a_top_pri: assert property (@(posedge clk) disable iff (!rst_n)
        rdq_top_valid |-> (rdq_top_tskpri == tskpri_tbl[rdq_top_tskid]))
        else $error("ready-queue top priority does not match the task table");

    a_add_absent: assert property (@(posedge clk) disable iff (!rst_n)
        add_valid |-> !ready_member[add_id])
        else $error("ready-queue add names a task that is already ready");

endmodule

bind rtos_core rtos_checker i_rtos_checker (
    .clk            (clk),
    .rst_n          (rst_n),
    .call_valid     ({wup_tsk_valid, slp_tsk_valid, rel_wai_valid,
                      wai_sem_valid, sig_sem_valid, wai_flg_valid}),
    .rdq_top_tskid  (rdq_top_tskid),
    .rdq_top_tskpri (rdq_top_tskpri),
    .rdq_top_valid  (rdq_top_valid),
    .add_id         (rdq_if.add_id),
    .add_valid      (rdq_if.add_valid),
    .ready_member   (i_ready_queue.member)
);

`default_nettype wire

/* sim/rtos_tb.sv */
// Table-driven testbench for the RTOS kernel core.
// Each step issues one service call (or only flag masks), lets the core
// settle for RTOS_TASKS+3 cycles and then compares the ready-queue top,
// the event flag and the semaphore counts with the expected values.

`default_nettype none

`include "rtos_cfg.svh"

module rtos_tb;

    import rtos_pkg::*;

    localparam int CLK_PERIOD    = 20;
    localparam int NUM_STEPS     = 24;
    localparam int CNT_WIDTH     = `RTOS_SEMAPHORES * `RTOS_SEMCNT_WIDTH;
    localparam int WATCHDOG_TIME = NUM_STEPS * (`RTOS_TASKS + 6) * CLK_PERIOD;

    // fixed task priorities by id, lower is more urgent
    localparam int TASK_PRI [`RTOS_TASKS] = '{3, 1, 2, 1, 0, 2, 3, 1};

    typedef enum logic [2:0] {
        call_none, call_wup, call_slp, call_rel, call_wsem, call_ssem, call_wflg
    } call_e;

    logic clk;
    logic rst_n;

    tskid_t  wup_tsk_tskid;
    logic    wup_tsk_valid;
    tskid_t  slp_tsk_tskid;
    logic    slp_tsk_valid;
    tskid_t  rel_wai_tskid;
    logic    rel_wai_valid;
    semid_t  wai_sem_semid;
    logic    wai_sem_valid;
    semid_t  sig_sem_semid;
    logic    sig_sem_valid;
    wfmode_e wai_flg_wfmode;
    flgptn_t wai_flg_flgptn;
    logic    wai_flg_valid;
    flgptn_t set_flg;
    flgptn_t clr_flg;
    tskid_t  rdq_top_tskid;
    tskpri_t rdq_top_tskpri;
    logic    rdq_top_valid;
    flgptn_t evtflg_flgptn;
    semcnt_t [`RTOS_SEMAPHORES-1:0] semcnt;

    // --------------------------------------------------
    // step table
    // --------------------------------------------------
    string                step_name [NUM_STEPS];
    call_e                step_call [NUM_STEPS];
    int                   step_id   [NUM_STEPS];
    wfmode_e              step_mode [NUM_STEPS];
    flgptn_t              step_ptn  [NUM_STEPS];
    flgptn_t              step_set  [NUM_STEPS];
    flgptn_t              step_clr  [NUM_STEPS];
    int                   exp_id    [NUM_STEPS];
    bit                   exp_valid [NUM_STEPS];
    flgptn_t              exp_flg   [NUM_STEPS];
    logic [CNT_WIDTH-1:0] exp_cnt   [NUM_STEPS];

    int num_defined  = 0;
    int mismatches   = 0;
    int failed_steps = 0;

    rtos_clkgen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (3)
    ) i_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rtos_core i_rtos_core (
        .clk            (clk),
        .rst_n          (rst_n),
        .wup_tsk_tskid  (wup_tsk_tskid),
        .wup_tsk_valid  (wup_tsk_valid),
        .slp_tsk_tskid  (slp_tsk_tskid),
        .slp_tsk_valid  (slp_tsk_valid),
        .rel_wai_tskid  (rel_wai_tskid),
        .rel_wai_valid  (rel_wai_valid),
        .wai_sem_semid  (wai_sem_semid),
        .wai_sem_valid  (wai_sem_valid),
        .sig_sem_semid  (sig_sem_semid),
        .sig_sem_valid  (sig_sem_valid),
        .wai_flg_wfmode (wai_flg_wfmode),
        .wai_flg_flgptn (wai_flg_flgptn),
        .wai_flg_valid  (wai_flg_valid),
        .set_flg        (set_flg),
        .clr_flg        (clr_flg),
        .rdq_top_tskid  (rdq_top_tskid),
        .rdq_top_tskpri (rdq_top_tskpri),
        .rdq_top_valid  (rdq_top_valid),
        .evtflg_flgptn  (evtflg_flgptn),
        .semcnt         (semcnt)
    );

    task automatic define_step(input string name, input call_e call, input int id,
                               input wfmode_e mode, input flgptn_t ptn, input flgptn_t set,
                               input flgptn_t clr, input int e_id, input bit e_valid,
                               input flgptn_t e_flg, input logic [CNT_WIDTH-1:0] e_cnt);
        step_name[num_defined] = name;
        step_call[num_defined] = call;
        step_id[num_defined]   = id;
        step_mode[num_defined] = mode;
        step_ptn[num_defined]  = ptn;
        step_set[num_defined]  = set;
        step_clr[num_defined]  = clr;
        exp_id[num_defined]    = e_id;
        exp_valid[num_defined] = e_valid;
        exp_flg[num_defined]   = e_flg;
        exp_cnt[num_defined]   = e_cnt;
        num_defined++;
    endtask

    // priorities 3 1 2 1 0 2 3 1; expected counts are {sem1, sem0}
    task automatic load_steps();
        define_step("reset_state", call_none, 0, wf_and, 8'h00, 8'h00, 8'h00,
                    4, 1'b1, 8'h00, 8'h00);
        define_step("slp_task4", call_slp, 4, wf_and, 8'h00, 8'h00, 8'h00, 1, 1'b1, 8'h00, 8'h00);
        define_step("wup_task4", call_wup, 4, wf_and, 8'h00, 8'h00, 8'h00, 4, 1'b1, 8'h00, 8'h00);
        define_step("wai_sem0_block", call_wsem, 0, wf_and, 8'h00, 8'h00, 8'h00,
                    1, 1'b1, 8'h00, 8'h00);
        define_step("sig_sem0_release", call_ssem, 0, wf_and, 8'h00, 8'h00, 8'h00,
                    4, 1'b1, 8'h00, 8'h00);
        define_step("sig_sem0_count", call_ssem, 0, wf_and, 8'h00, 8'h00, 8'h00,
                    4, 1'b1, 8'h00, 8'h01);
        define_step("wai_sem0_take", call_wsem, 0, wf_and, 8'h00, 8'h00, 8'h00,
                    4, 1'b1, 8'h00, 8'h00);
        // AND wait needs both bits
        define_step("wai_flg_and", call_wflg, 0, wf_and, 8'h05, 8'h00, 8'h00,
                    1, 1'b1, 8'h00, 8'h00);
        define_step("set_flg_bit0", call_none, 0, wf_and, 8'h00, 8'h01, 8'h00,
                    1, 1'b1, 8'h01, 8'h00);
        define_step("set_flg_bit2", call_none, 0, wf_and, 8'h00, 8'h04, 8'h00,
                    4, 1'b1, 8'h05, 8'h00);
        define_step("clr_flg_all", call_none, 0, wf_and, 8'h00, 8'h00, 8'hff,
                    4, 1'b1, 8'h00, 8'h00);
        define_step("wai_flg_or", call_wflg, 0, wf_or, 8'h30, 8'h00, 8'h00,
                    1, 1'b1, 8'h00, 8'h00);
        define_step("set_flg_bit4", call_none, 0, wf_and, 8'h00, 8'h10, 8'h00,
                    4, 1'b1, 8'h10, 8'h00);
        define_step("wai_sem1_block", call_wsem, 1, wf_and, 8'h00, 8'h00, 8'h00,
                    1, 1'b1, 8'h10, 8'h00);
        define_step("rel_wai_task4", call_rel, 4, wf_and, 8'h00, 8'h00, 8'h00,
                    4, 1'b1, 8'h10, 8'h00);
        define_step("sig_sem1_count", call_ssem, 1, wf_and, 8'h00, 8'h00, 8'h00,
                    4, 1'b1, 8'h10, 8'h10);
        // put every task to sleep, lowest id first
        define_step("slp_task0", call_slp, 0, wf_and, 8'h00, 8'h00, 8'h00, 4, 1'b1, 8'h10, 8'h10);
        define_step("slp_task1", call_slp, 1, wf_and, 8'h00, 8'h00, 8'h00, 4, 1'b1, 8'h10, 8'h10);
        define_step("slp_task2", call_slp, 2, wf_and, 8'h00, 8'h00, 8'h00, 4, 1'b1, 8'h10, 8'h10);
        define_step("slp_task3", call_slp, 3, wf_and, 8'h00, 8'h00, 8'h00, 4, 1'b1, 8'h10, 8'h10);
        define_step("slp_task4_all", call_slp, 4, wf_and, 8'h00, 8'h00, 8'h00,
                    7, 1'b1, 8'h10, 8'h10);
        define_step("slp_task5", call_slp, 5, wf_and, 8'h00, 8'h00, 8'h00, 7, 1'b1, 8'h10, 8'h10);
        define_step("slp_task6", call_slp, 6, wf_and, 8'h00, 8'h00, 8'h00, 7, 1'b1, 8'h10, 8'h10);
        define_step("slp_task7", call_slp, 7, wf_and, 8'h00, 8'h00, 8'h00, 0, 1'b0, 8'h10, 8'h10);
    endtask

    task automatic clear_calls();
        wup_tsk_tskid  = '0;
        wup_tsk_valid  = 1'b0;
        slp_tsk_tskid  = '0;
        slp_tsk_valid  = 1'b0;
        rel_wai_tskid  = '0;
        rel_wai_valid  = 1'b0;
        wai_sem_semid  = '0;
        wai_sem_valid  = 1'b0;
        sig_sem_semid  = '0;
        sig_sem_valid  = 1'b0;
        wai_flg_wfmode = wf_and;
        wai_flg_flgptn = '0;
        wai_flg_valid  = 1'b0;
        set_flg        = '0;
        clr_flg        = '0;
    endtask

    task automatic drive_call(input int i);
        set_flg = step_set[i];
        clr_flg = step_clr[i];
        case (step_call[i])
            call_wup: begin
                wup_tsk_tskid = tskid_t'(step_id[i]);
                wup_tsk_valid = 1'b1;
            end
            call_slp: begin
                slp_tsk_tskid = tskid_t'(step_id[i]);
                slp_tsk_valid = 1'b1;
            end
            call_rel: begin
                rel_wai_tskid = tskid_t'(step_id[i]);
                rel_wai_valid = 1'b1;
            end
            call_wsem: begin
                wai_sem_semid = semid_t'(step_id[i]);
                wai_sem_valid = 1'b1;
            end
            call_ssem: begin
                sig_sem_semid = semid_t'(step_id[i]);
                sig_sem_valid = 1'b1;
            end
            call_wflg: begin
                wai_flg_wfmode = step_mode[i];
                wai_flg_flgptn = step_ptn[i];
                wai_flg_valid  = 1'b1;
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %0h, actual %0h", what, expected, actual);
            mismatches++;
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        int errors_before;

        clear_calls();
        load_steps();
        @(posedge rst_n);
        for (int i = 0; i < NUM_STEPS; i++) begin
            @(negedge clk);
            drive_call(i);
            @(negedge clk);
            clear_calls();
            // worst-case release is RTOS_TASKS+2 cycles
            repeat (`RTOS_TASKS + 3) @(negedge clk);
            errors_before = mismatches;
            check_value({step_name[i], " rdq_top_valid"}, 32'(exp_valid[i]),
                        32'(rdq_top_valid));
            if (exp_valid[i]) begin
                check_value({step_name[i], " rdq_top_tskid"}, 32'(exp_id[i]),
                            32'(rdq_top_tskid));
                check_value({step_name[i], " rdq_top_tskpri"}, 32'(TASK_PRI[exp_id[i]]),
                            32'(rdq_top_tskpri));
            end
            check_value({step_name[i], " evtflg_flgptn"}, 32'(exp_flg[i]),
                        32'(evtflg_flgptn));
            check_value({step_name[i], " semcnt"}, 32'(exp_cnt[i]), 32'(semcnt));
            if (mismatches != errors_before) begin
                failed_steps++;
            end
            $display("step %0d %s: %s", i, step_name[i],
                     (mismatches == errors_before) ? "ok" : "FAIL");
        end
        $display("%0d steps run, %0d steps failed, %0d mismatches",
                 NUM_STEPS, failed_steps, mismatches);
        if (mismatches == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: the steps did not finish within %0d time units", WATCHDOG_TIME);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+source
source/rtos_pkg.sv
source/rtos_queue_if.sv
source/rtos_prio_queue.sv
source/rtos_task.sv
source/rtos_semaphore.sv
source/rtos_core.sv
sim/rtos_clkgen.sv
sim/rtos_checker.sv
sim/rtos_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := rtos_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
